/* logic/replay_pkg.sv */
// Shared widths, register map, reset defaults and payload structs for the pcap replay engine
`default_nettype none

package replay_pkg;

  // Stream and memory sizing
  localparam int DATA_W     = 64;
  localparam int MEM_ADDR_W = 6;
  localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

  // Register port sizing
  localparam int REG_ADDR_W = 3;
  localparam int REG_DATA_W = 32;
  localparam int COUNT_W    = 32;

  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_SW_RST    = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_START     = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_COUNT     = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_ADDR_LOW  = 3'd3;
  localparam logic [REG_ADDR_W-1:0] REG_ADDR_HIGH = 3'd4;
  localparam logic [REG_ADDR_W-1:0] REG_ENABLE    = 3'd5;

  // Values loaded by a hard reset
  localparam logic [COUNT_W-1:0]    DEF_COUNT     = 32'd10;
  localparam logic [MEM_ADDR_W-1:0] DEF_ADDR_LOW  = 6'd0;
  localparam logic [MEM_ADDR_W-1:0] DEF_ADDR_HIGH = 6'd15;
  localparam logic                  DEF_ENABLE    = 1'b1;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } axis_word_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] data;
  } reg_wr_t;

  // Live replay configuration seen by the engine
  typedef struct packed {
    logic [COUNT_W-1:0]    count;
    logic [MEM_ADDR_W-1:0] addr_low;
    logic [MEM_ADDR_W-1:0] addr_high;
    logic                  enable;
  } replay_cfg_t;

endpackage

`default_nettype wire

/* logic/stream_slice.sv */
// Two-entry valid/ready buffer, instantiated for register writes and for the replay output
`timescale 1ns/1ps
`default_nettype none

module stream_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     s_axi_aclk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t   buf_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Ready depends only on occupancy, so no path from out_ready to in_ready
  assign in_ready  = (count_q != 2'd2);
  assign out_valid = (count_q != 2'd0);
  assign out_data  = buf_q[rd_ptr_q];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (push) buf_q[wr_ptr_q] <= in_data;
  end

endmodule

`default_nettype wire

/* logic/replay_regs.sv */
// Control register bank, written by software through the buffered register write port
`timescale 1ns/1ps
`default_nettype none

module replay_regs (
  input  logic                     s_axi_aclk,
  input  logic                     rst,
  input  replay_pkg::reg_wr_t      wr,
  input  logic                     wr_valid,
  output logic                     wr_ready,
  output replay_pkg::replay_cfg_t  cfg,
  output logic                     start_pulse,
  output logic                     soft_rst
);

  import replay_pkg::*;

  logic [COUNT_W-1:0]    count_q;
  logic [MEM_ADDR_W-1:0] addr_low_q;
  logic [MEM_ADDR_W-1:0] addr_high_q;
  logic                  enable_q;
  logic                  sw_rst_q;
  logic                  start_q;
  logic                  wr_fire;

  // Bank takes a write every cycle
  assign wr_ready = 1'b1;
  assign wr_fire  = wr_valid && wr_ready;

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      count_q     <= DEF_COUNT;
      addr_low_q  <= DEF_ADDR_LOW;
      addr_high_q <= DEF_ADDR_HIGH;
      enable_q    <= DEF_ENABLE;
      sw_rst_q    <= 1'b0;
      start_q     <= 1'b0;
    end else begin
      // Start self-clears after one cycle
      start_q <= 1'b0;
      if (wr_fire) begin
        case (wr.addr)
          REG_SW_RST:    sw_rst_q    <= wr.data[0];
          REG_START:     start_q     <= wr.data[0];
          REG_COUNT:     count_q     <= wr.data[COUNT_W-1:0];
          REG_ADDR_LOW:  addr_low_q  <= wr.data[MEM_ADDR_W-1:0];
          REG_ADDR_HIGH: addr_high_q <= wr.data[MEM_ADDR_W-1:0];
          REG_ENABLE:    enable_q    <= wr.data[0];
          // Unmapped addresses are dropped
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    cfg.count     = count_q;
    cfg.addr_low  = addr_low_q;
    cfg.addr_high = addr_high_q;
    cfg.enable    = enable_q;
  end

  assign start_pulse = start_q;
  assign soft_rst    = sw_rst_q;

endmodule

`default_nettype wire

/* logic/replay_fsm.sv */
// Replay control FSM that launches a replay, paces words into the output and ends it
`timescale 1ns/1ps
`default_nettype none

module replay_fsm (
  input  logic                    s_axi_aclk,
  input  logic                    rst,
  input  replay_pkg::replay_cfg_t cfg,
  input  logic                    start_pulse,
  input  logic                    pass_end,
  input  logic                    final_pass,
  input  logic                    out_ready,
  output logic                    load,
  output logic                    step,
  output logic                    out_valid,
  output logic                    busy
);

  typedef enum logic {
    IDLE,
    REPLAY
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   last_word;

  // A start only counts when enabled and there is work to do
  assign load = (state_q == IDLE) && start_pulse && cfg.enable && (cfg.count != '0);

  assign out_valid = (state_q == REPLAY);
  assign busy      = (state_q == REPLAY);

  // One word leaves memory per accepted handshake
  assign step = out_valid && out_ready;

  // Top address of the final pass accepted
  assign last_word = step && pass_end && final_pass;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (load) state_d = REPLAY;
      end
      REPLAY: begin
        if (last_word) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* logic/replay_counter.sv */
// Memory read pointer and remaining-pass counter that walk the replay window
`timescale 1ns/1ps
`default_nettype none

module replay_counter (
  input  logic                              s_axi_aclk,
  input  logic                              rst,
  input  replay_pkg::replay_cfg_t           cfg,
  input  logic                              load,
  input  logic                              step,
  output logic [replay_pkg::MEM_ADDR_W-1:0] rd_addr,
  output logic                              pass_end,
  output logic                              final_pass
);

  import replay_pkg::*;

  logic [MEM_ADDR_W-1:0] addr_q;
  logic [COUNT_W-1:0]    remain_q;

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      addr_q   <= '0;
      remain_q <= '0;
    end else if (load) begin
      addr_q   <= cfg.addr_low;
      remain_q <= cfg.count;
    end else if (step) begin
      if (pass_end) begin
        // Wrap back to the window start for the next pass
        addr_q   <= cfg.addr_low;
        remain_q <= remain_q - 1'b1;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign rd_addr    = addr_q;
  assign pass_end   = (addr_q == cfg.addr_high);
  assign final_pass = (remain_q == COUNT_W'(1));

endmodule

`default_nettype wire

/* logic/pkt_mem.sv */
// Packet memory filled by the capture stream and read combinationally during replay
`timescale 1ns/1ps
`default_nettype none

module pkt_mem (
  input  logic                              s_axi_aclk,
  input  logic                              rst,
  input  replay_pkg::axis_word_t            wr_word,
  input  logic                              wr_valid,
  input  logic                              wr_en_ok,
  output logic                              wr_ready,
  input  logic [replay_pkg::MEM_ADDR_W-1:0] rd_addr,
  output replay_pkg::axis_word_t            rd_word
);

  import replay_pkg::*;

  axis_word_t            mem_q [MEM_DEPTH];
  logic [MEM_ADDR_W-1:0] wr_ptr_q;
  logic                  wr_fire;

  // Capture only while the engine leaves the memory alone
  assign wr_ready = wr_en_ok;
  assign wr_fire  = wr_valid && wr_ready;

  // Pointer wraps naturally at the memory depth
  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      wr_ptr_q <= '0;
    end else if (wr_fire) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (wr_fire) begin
      mem_q[wr_ptr_q] <= wr_word;
    end
  end

  // Asynchronous read keeps one word per cycle into the output slice
  assign rd_word = mem_q[rd_addr];

endmodule

`default_nettype wire

/* logic/pcap_replay_top.sv */
// Top level of the pcap replay engine, connecting register bank, control, memory and slices
`timescale 1ns/1ps
`default_nettype none

module pcap_replay_top (
  input  logic                   s_axi_aclk,
  input  logic                   rst,
  input  replay_pkg::reg_wr_t    reg_wr,
  input  logic                   reg_wr_valid,
  output logic                   reg_wr_ready,
  input  replay_pkg::axis_word_t s_axis,
  input  logic                   s_axis_valid,
  output logic                   s_axis_ready,
  output replay_pkg::axis_word_t m_axis,
  output logic                   m_axis_valid,
  input  logic                   m_axis_ready,
  output logic                   replay_busy
);

  import replay_pkg::*;

  reg_wr_t               wr_q;
  logic                  wr_q_valid;
  logic                  wr_q_ready;
  replay_cfg_t           cfg;
  logic                  start_pulse;
  logic                  soft_rst;
  logic                  eng_rst;
  logic                  load;
  logic                  step;
  logic                  pass_end;
  logic                  final_pass;
  logic [MEM_ADDR_W-1:0] rd_addr;
  axis_word_t            rd_word;
  logic                  rd_valid;
  logic                  rd_ready;
  logic                  capture_ok;

  // Soft reset clears the datapath but not the register bank
  assign eng_rst    = rst | soft_rst;
  assign capture_ok = ~(replay_busy | soft_rst);

  stream_slice #(.payload_t(reg_wr_t)) reg_slice_i (
    .s_axi_aclk(s_axi_aclk), .rst(rst),
    .in_data(reg_wr), .in_valid(reg_wr_valid), .in_ready(reg_wr_ready),
    .out_data(wr_q), .out_valid(wr_q_valid), .out_ready(wr_q_ready)
  );

  replay_regs regs_i (
    .s_axi_aclk(s_axi_aclk), .rst(rst),
    .wr(wr_q), .wr_valid(wr_q_valid), .wr_ready(wr_q_ready),
    .cfg(cfg), .start_pulse(start_pulse), .soft_rst(soft_rst)
  );

  replay_fsm fsm_i (
    .s_axi_aclk(s_axi_aclk), .rst(eng_rst), .cfg(cfg), .start_pulse(start_pulse),
    .pass_end(pass_end), .final_pass(final_pass), .out_ready(rd_ready),
    .load(load), .step(step), .out_valid(rd_valid), .busy(replay_busy)
  );

  replay_counter counter_i (
    .s_axi_aclk(s_axi_aclk), .rst(eng_rst), .cfg(cfg), .load(load), .step(step),
    .rd_addr(rd_addr), .pass_end(pass_end), .final_pass(final_pass)
  );

  pkt_mem mem_i (
    .s_axi_aclk(s_axi_aclk), .rst(eng_rst),
    .wr_word(s_axis), .wr_valid(s_axis_valid), .wr_en_ok(capture_ok),
    .wr_ready(s_axis_ready), .rd_addr(rd_addr), .rd_word(rd_word)
  );

  stream_slice #(.payload_t(axis_word_t)) out_slice_i (
    .s_axi_aclk(s_axi_aclk), .rst(eng_rst),
    .in_data(rd_word), .in_valid(rd_valid), .in_ready(rd_ready),
    .out_data(m_axis), .out_valid(m_axis_valid), .out_ready(m_axis_ready)
  );

endmodule

`default_nettype wire

/* tests/replay_chk.sv */
// Protocol assertions for the replay engine, attached to the top level with bind
`timescale 1ns/1ps
`default_nettype none

module replay_chk (
  input logic                   s_axi_aclk,
  input logic                   rst,
  input logic                   eng_rst,
  input replay_pkg::axis_word_t m_axis,
  input logic                   m_axis_valid,
  input logic                   m_axis_ready,
  input logic                   s_axis_ready,
  input logic                   replay_busy
);

  // Stalled output word must not change or vanish
  a_out_hold: assert property (@(posedge s_axi_aclk) disable iff (eng_rst)
    (m_axis_valid && !m_axis_ready) |=> (m_axis_valid && $stable(m_axis)))
    else $error("output word changed while stalled");

  // No capture while a replay reads the memory
  a_no_capture: assert property (@(posedge s_axi_aclk) disable iff (rst)
    replay_busy |-> !s_axis_ready)
    else $error("capture port ready during replay");

  a_idle_after_rst: assert property (@(posedge s_axi_aclk) rst |=> !replay_busy)
    else $error("replay_busy high right after reset");

endmodule

bind pcap_replay_top replay_chk chk_i (
  .s_axi_aclk(s_axi_aclk), .rst(rst), .eng_rst(eng_rst),
  .m_axis(m_axis), .m_axis_valid(m_axis_valid), .m_axis_ready(m_axis_ready),
  .s_axis_ready(s_axis_ready), .replay_busy(replay_busy)
);

`default_nettype wire

/* tests/tb_pcap_replay.sv */
// Testbench for the pcap replay engine; captures packets, runs a table of replays, checks output
`timescale 1ns/1ps
`default_nettype none

module tb_pcap_replay;

  import replay_pkg::*;

  typedef struct packed {
    logic [31:0] count;
    logic [5:0]  low;
    logic [5:0]  high;
    logic        enable;
    logic        bp;
  } row_t;

  localparam int NUM_ROWS = 7;
  localparam int TIMEOUT  = 2000;

  logic       s_axi_aclk;
  logic       rst;
  reg_wr_t    reg_wr;
  logic       reg_wr_valid;
  logic       reg_wr_ready;
  axis_word_t s_axis;
  logic       s_axis_valid;
  logic       s_axis_ready;
  axis_word_t m_axis;
  logic       m_axis_valid;
  logic       m_axis_ready;
  logic       replay_busy;

  integer     seed;
  logic       bp_on;
  axis_word_t mem_model [MEM_DEPTH];
  axis_word_t got_q [$];
  axis_word_t exp_q [$];
  row_t       rows [NUM_ROWS];

  pcap_replay_top dut_i (.*);

  initial begin
    s_axi_aclk = 1'b0;
    forever #4 s_axi_aclk = ~s_axi_aclk;
  end

  // Sink picks ready first, then logs the word the next rising edge takes
  initial begin
    m_axis_ready = 1'b0;
    forever begin
      @(negedge s_axi_aclk);
      m_axis_ready = bp_on ? 1'($random(seed)) : 1'b1;
      if (m_axis_valid && m_axis_ready) got_q.push_back(m_axis);
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    int waited;
    @(negedge s_axi_aclk);
    reg_wr.addr  = addr;
    reg_wr.data  = data;
    reg_wr_valid = 1'b1;
    waited = 0;
    while (!reg_wr_ready) begin
      if (waited == TIMEOUT) fail_run("register write port never became ready");
      waited++;
      @(negedge s_axi_aclk);
    end
    @(negedge s_axi_aclk);
    reg_wr_valid = 1'b0;
  endtask

  task automatic capture_word(input axis_word_t w);
    int waited;
    @(negedge s_axi_aclk);
    s_axis       = w;
    s_axis_valid = 1'b1;
    waited = 0;
    while (!s_axis_ready) begin
      if (waited == TIMEOUT) fail_run("capture port never became ready");
      waited++;
      @(negedge s_axi_aclk);
    end
    @(negedge s_axi_aclk);
    s_axis_valid = 1'b0;
  endtask

  // Random words for addresses 0 to n-1 with a periodic last flag
  task automatic capture_words(input int n, input int last_every);
    axis_word_t w;
    for (int i = 0; i < n; i++) begin
      w.data = {$random(seed), $random(seed)};
      w.last = (i % last_every == last_every - 1);
      mem_model[i] = w;
      capture_word(w);
    end
  endtask

  task automatic wait_busy(input logic level);
    int waited;
    waited = 0;
    while (replay_busy !== level) begin
      if (waited == TIMEOUT) fail_run($sformatf("replay_busy did not go to %0d", level));
      waited++;
      @(negedge s_axi_aclk);
    end
  endtask

  // Output slice empties once the sink has taken every word
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (m_axis_valid !== 1'b0) begin
      if (waited == TIMEOUT) fail_run("output stream did not drain");
      waited++;
      @(negedge s_axi_aclk);
    end
  endtask

  task automatic config_row(input row_t r);
    write_reg(REG_COUNT, r.count);
    write_reg(REG_ADDR_LOW, 32'(r.low));
    write_reg(REG_ADDR_HIGH, 32'(r.high));
    write_reg(REG_ENABLE, 32'(r.enable));
  endtask

  task automatic run_replay(input row_t r, input string tag);
    exp_q.delete();
    if (r.enable && r.count != 0) begin
      for (int p = 0; p < int'(r.count); p++) begin
        for (int a = int'(r.low); a <= int'(r.high); a++) exp_q.push_back(mem_model[a]);
      end
    end
    bp_on = r.bp;
    got_q.delete();
    write_reg(REG_START, 32'd1);
    if (exp_q.size() == 0) begin
      repeat (50) begin
        @(negedge s_axi_aclk);
        check_value({tag, " replay_busy"}, 64'(replay_busy), 64'd0);
        check_value({tag, " m_axis_valid"}, 64'(m_axis_valid), 64'd0);
      end
    end else begin
      wait_busy(1'b1);
      wait_busy(1'b0);
      wait_drain();
    end
    check_value({tag, " word count"}, 64'(got_q.size()), 64'(exp_q.size()));
    foreach (exp_q[i]) begin
      check_value($sformatf("%s m_axis.data[%0d]", tag, i), got_q[i].data, exp_q[i].data);
      check_value($sformatf("%s m_axis.last[%0d]", tag, i), 64'(got_q[i].last),
                  64'(exp_q[i].last));
    end
  endtask

  initial begin
    row_t       extra;
    seed         = 68433;
    rst          = 1'b1;
    bp_on        = 1'b0;
    reg_wr       = '0;
    reg_wr_valid = 1'b0;
    s_axis       = '0;
    s_axis_valid = 1'b0;

    // count, low, high, enable, back-pressure
    rows[0] = '{32'd3, 6'd20, 6'd27, 1'b1, 1'b0};
    rows[1] = '{32'd2, 6'd40, 6'd63, 1'b1, 1'b0};
    rows[2] = '{32'd3, 6'd20, 6'd27, 1'b1, 1'b1};
    rows[3] = '{32'd5, 6'd5, 6'd5, 1'b1, 1'b1};
    rows[4] = '{32'd4, 6'd0, 6'd15, 1'b1, 1'b1};
    rows[5] = '{32'd4, 6'd8, 6'd12, 1'b0, 1'b0};
    rows[6] = '{32'd0, 6'd8, 6'd12, 1'b1, 1'b0};

    repeat (2) @(negedge s_axi_aclk);
    rst = 1'b0;

    capture_words(MEM_DEPTH, 8);

    // Registers still hold their reset values here
    extra = '{32'd10, 6'd0, 6'd15, 1'b1, 1'b0};
    run_replay(extra, "default");

    for (int r = 0; r < NUM_ROWS; r++) begin
      config_row(rows[r]);
      run_replay(rows[r], $sformatf("row %0d", r));
    end

    // Leave the capture pointer away from address 0
    capture_words(5, 8);

    // Soft reset in the middle of a long replay
    extra = '{32'd1000, 6'd0, 6'd15, 1'b1, 1'b0};
    config_row(extra);
    bp_on = 1'b0;
    write_reg(REG_START, 32'd1);
    wait_busy(1'b1);
    repeat (8) @(negedge s_axi_aclk);
    write_reg(REG_SW_RST, 32'd1);
    wait_busy(1'b0);
    wait_drain();
    check_value("s_axis_ready", 64'(s_axis_ready), 64'd0);
    write_reg(REG_SW_RST, 32'd0);

    // Capture pointer restarted at address 0
    capture_words(4, 4);
    extra = '{32'd1, 6'd0, 6'd3, 1'b1, 1'b0};
    config_row(extra);
    run_replay(extra, "after soft reset");

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
logic/replay_pkg.sv
logic/stream_slice.sv
logic/replay_regs.sv
logic/replay_fsm.sv
logic/replay_counter.sv
logic/pkt_mem.sv
logic/pcap_replay_top.sv
tests/replay_chk.sv
tests/tb_pcap_replay.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f files.f --top-module tb_pcap_replay -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
